// ==== common/fpu_f2i_pkg.sv ====
// float to int conversion package
// widths, rounding-mode codes and saturation values shared by all stages

`default_nettype none

package fpu_f2i_pkg;

  //////////////////////////////////////////////////
  // operand and intermediate widths
  //////////////////////////////////////////////////

  // raw single-precision operand
  typedef logic [31:0] fp32_t;
  // biased exponent, top bits catch the borrow when the bias is removed
  typedef logic [9:0] exp10_t;
  // mantissa including the hidden bit
  typedef logic [23:0] fract24_t;
  // right shift, saturates at 31
  typedef logic [4:0] shr_t;
  // left shift, saturates at 15
  typedef logic [3:0] shl_t;
  // signed integer result
  typedef logic [31:0] int32_t;

  //////////////////////////////////////////////////
  // rounding modes
  //////////////////////////////////////////////////

  typedef logic [2:0] rm_t;

  localparam rm_t RM_RNE = 3'd0;
  localparam rm_t RM_RTZ = 3'd1;
  localparam rm_t RM_RDN = 3'd2;
  localparam rm_t RM_RUP = 3'd3;
  localparam rm_t RM_RMM = 3'd4;
  // codes 5..7 fall back to round to nearest even

  //////////////////////////////////////////////////
  // conversion constants
  //////////////////////////////////////////////////

  // exponent bias 127 plus 23 fraction bits
  localparam exp10_t F2I_BIAS_SHIFT = 10'd150;

  // saturation values, NaN goes to the positive one
  localparam int32_t INT_POS_SAT = 32'h7fff_ffff;
  localparam int32_t INT_NEG_SAT = 32'h8000_0000;

endpackage

`default_nettype wire

// ==== common/fpu_f2i_if.sv ====
// float to int pipeline stage links
// upstream stage drives everything, downstream stage only reads

`default_nettype none

// stage 0 to stage 1
interface unpack_if;
  logic                     vld;
  logic                     sign;
  fpu_f2i_pkg::exp10_t      exp10;
  fpu_f2i_pkg::fract24_t    fract24;
  logic                     snan;
  logic                     qnan;
  fpu_f2i_pkg::rm_t         rm;

  modport src (output vld, sign, exp10, fract24, snan, qnan, rm);
  modport dst (input  vld, sign, exp10, fract24, snan, qnan, rm);
endinterface

// stage 1 to stage 2
interface prep_if;
  logic                     vld;
  logic                     sign;
  fpu_f2i_pkg::fract24_t    int24;
  fpu_f2i_pkg::shr_t        shr;
  fpu_f2i_pkg::shl_t        shl;
  logic                     ovf;
  // signaling NaN
  logic                     snan;
  // quiet NaN, merged with snan in the next stage
  logic                     nan;
  fpu_f2i_pkg::rm_t         rm;

  modport src (output vld, sign, int24, shr, shl, ovf, snan, nan, rm);
  modport dst (input  vld, sign, int24, shr, shl, ovf, snan, nan, rm);
endinterface

// stage 2 to stage 3
interface shift_if;
  logic                     vld;
  logic                     sign;
  fpu_f2i_pkg::int32_t      mag;
  logic                     guard;
  logic                     sticky;
  logic                     ovf;
  logic                     nan;
  fpu_f2i_pkg::rm_t         rm;

  modport src (output vld, sign, mag, guard, sticky, ovf, nan, rm);
  modport dst (input  vld, sign, mag, guard, sticky, ovf, nan, rm);
endinterface

`default_nettype wire

// ==== design/fpu_f2i_credit.sv ====
// credit control for the float to int pipeline
// one credit per consumer slot, operands are only taken while a credit is held

`default_nettype none

module fpu_f2i_credit #(
  parameter int CREDITS = 4
) (
  input  wire clk,
  input  wire rst,
  input  wire flush_i,
  input  wire in_valid_i,
  input  wire credit_i,
  input  wire res_valid_i,
  output wire accept_o,
  output wire in_ready_o
);

  // credits on hand, and items accepted but not yet delivered
  logic [3:0] cnt_q;
  logic [3:0] fly_q;
  logic [4:0] cnt_nxt;

  // no new operand during a flush cycle
  assign in_ready_o = (cnt_q != 4'd0) && !flush_i;
  assign accept_o   = in_valid_i && in_ready_o;

  always_comb begin
    cnt_nxt = {1'b0, cnt_q};
    if (accept_o) begin
      cnt_nxt = cnt_nxt - 5'd1;
    end
    if (credit_i) begin
      cnt_nxt = cnt_nxt + 5'd1;
    end
    // killed items hand back their slot
    // a result showing this cycle still lands in the consumer
    if (flush_i) begin
      cnt_nxt = cnt_nxt + {1'b0, fly_q} - {4'd0, res_valid_i};
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_q <= 4'(CREDITS);
      fly_q <= 4'd0;
    end else begin
      cnt_q <= cnt_nxt[3:0];
      if (flush_i) begin
        fly_q <= 4'd0;
      end else begin
        fly_q <= fly_q + {3'd0, accept_o} - {3'd0, res_valid_i};
      end
    end
  end

  // held credits plus items in the pipe never outnumber the consumer slots
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    ({1'b0, cnt_q} + {1'b0, fly_q}) <= 5'(CREDITS));

  // an accept always claims a slot the consumer really has free
  a_accept_credit: assert property (@(posedge clk) disable iff (rst)
    accept_o |-> (fly_q < 4'(CREDITS)));

  // returned credits never push the count past four bits
  a_count_wrap: assert property (@(posedge clk) disable iff (rst)
    !cnt_nxt[4]);

endmodule

`default_nettype wire

// ==== f2i/fpu_f2i_unpack.sv ====
// float to int stage 0
// splits the IEEE operand into fields and classifies NaNs

`default_nettype none

module fpu_f2i_unpack (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 flush_i,
  input  wire                 vld_i,
  input  fpu_f2i_pkg::fp32_t  op_i,
  input  fpu_f2i_pkg::rm_t    rm_i,
  unpack_if.src               out
);

  logic [7:0]  exp8;
  logic [22:0] fract23;
  logic        exp_zero;
  logic        exp_ones;

  assign exp8     = op_i[30:23];
  assign fract23  = op_i[22:0];
  assign exp_zero = (exp8 == 8'h00);
  assign exp_ones = (exp8 == 8'hff);

  // valid bit, cleared by flush
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out.vld <= 1'b0;
    end else if (flush_i) begin
      out.vld <= 1'b0;
    end else begin
      out.vld <= vld_i;
    end
  end

  // payload only moves with a valid operand
  always_ff @(posedge clk) begin
    if (vld_i) begin
      out.sign    <= op_i[31];
      // denormals sit at exponent 1 without the hidden bit
      out.exp10   <= {2'b00, exp_zero ? 8'd1 : exp8};
      out.fract24 <= {~exp_zero, fract23};
      // top fraction bit clear means signaling
      out.snan    <= exp_ones && !fract23[22] && (|fract23[21:0]);
      out.qnan    <= exp_ones && fract23[22];
      // infinity is not flagged, its exponent overflows later
      out.rm      <= rm_i;
    end
  end

endmodule

`default_nettype wire

// ==== f2i/fpu_f2i_prep.sv ====
// float to int stage 1
// removes the bias, picks the shift direction and flags early overflow

`default_nettype none

module fpu_f2i_prep (
  input  wire   clk,
  input  wire   rst,
  input  wire   flush_i,
  unpack_if.dst in,
  prep_if.src   out
);

  fpu_f2i_pkg::exp10_t exp10m;
  fpu_f2i_pkg::exp10_t shr_full;
  fpu_f2i_pkg::shr_t   shr;
  fpu_f2i_pkg::shl_t   shl;
  logic                shl_gt8;
  logic                shl_eq8;
  logic                ovf;

  // binary point moved to the right of the mantissa
  assign exp10m   = in.exp10 - fpu_f2i_pkg::F2I_BIAS_SHIFT;
  // negative result means a right shift is needed
  assign shr_full = fpu_f2i_pkg::F2I_BIAS_SHIFT - in.exp10;

  // right shift, saturated at 31
  assign shr = !exp10m[9] ? 5'd0 :
               (|shr_full[9:5]) ? 5'd31 : shr_full[4:0];
  // left shift, saturated at 15
  assign shl = exp10m[9] ? 4'd0 :
               (|exp10m[9:4]) ? 4'd15 : exp10m[3:0];

  // shift of 8 puts the hidden bit at 2^31
  assign shl_gt8 = shl[3] && (|shl[2:0]);
  assign shl_eq8 = shl[3] && !(|shl[2:0]);
  // only -2^31 itself fits at a shift of 8
  assign ovf = shl_gt8 || (shl_eq8 && (!in.sign || (|in.fract24[22:0])));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out.vld <= 1'b0;
    end else if (flush_i) begin
      out.vld <= 1'b0;
    end else begin
      out.vld <= in.vld;
    end
  end

  always_ff @(posedge clk) begin
    if (in.vld) begin
      // NaN saturates to the positive limit
      out.sign  <= in.sign && !(in.snan || in.qnan);
      out.int24 <= in.fract24;
      out.shr   <= shr;
      out.shl   <= shl;
      out.ovf   <= ovf;
      out.snan  <= in.snan;
      out.nan   <= in.qnan;
      out.rm    <= in.rm;
    end
  end

endmodule

`default_nettype wire

// ==== f2i/fpu_f2i_shift.sv ====
// float to int stage 2
// aligns the mantissa to a 32-bit magnitude with guard and sticky

`default_nettype none

module fpu_f2i_shift (
  input  wire  clk,
  input  wire  rst,
  input  wire  flush_i,
  prep_if.dst  in,
  shift_if.src out
);

  // integer part in [63:32], fraction below
  logic [63:0] ext;
  logic [63:0] aligned;

  assign ext = {8'd0, in.int24, 32'd0};
  // at most one of shl and shr is nonzero
  // bits lost off the top only matter when ovf is already set
  assign aligned = (ext << in.shl) >> in.shr;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out.vld <= 1'b0;
    end else if (flush_i) begin
      out.vld <= 1'b0;
    end else begin
      out.vld <= in.vld;
    end
  end

  always_ff @(posedge clk) begin
    if (in.vld) begin
      out.sign   <= in.sign;
      out.mag    <= aligned[63:32];
      // first bit below the point
      out.guard  <= aligned[31];
      // everything further down
      out.sticky <= |aligned[30:0];
      out.ovf    <= in.ovf;
      // both NaN kinds saturate the same way
      out.nan    <= in.snan || in.nan;
      out.rm     <= in.rm;
    end
  end

endmodule

`default_nettype wire

// ==== f2i/fpu_f2i_round.sv ====
// float to int stage 3
// rounds, applies the sign, saturates and registers result and flags

`default_nettype none

module fpu_f2i_round (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  flush_i,
  shift_if.dst                 in,
  output logic                 res_valid_o,
  output fpu_f2i_pkg::int32_t  res_int_o,
  output logic                 res_invalid_o,
  output logic                 res_inexact_o
);

  logic                inexact;
  logic                inc;
  logic [32:0]         rnd;
  logic                range_ovf;
  logic                invalid;
  fpu_f2i_pkg::int32_t res;

  // something nonzero fell off below the point
  assign inexact = in.guard || in.sticky;

  //////////////////////////////////////////////////
  // rounding increment per mode
  //////////////////////////////////////////////////

  always_comb begin
    case (in.rm)
      fpu_f2i_pkg::RM_RTZ: inc = 1'b0;
      // toward -inf grows the magnitude of negatives
      fpu_f2i_pkg::RM_RDN: inc = in.sign && inexact;
      fpu_f2i_pkg::RM_RUP: inc = !in.sign && inexact;
      // ties away from zero
      fpu_f2i_pkg::RM_RMM: inc = in.guard;
      // RNE and unused codes, ties to even
      default:             inc = in.guard && (in.sticky || in.mag[0]);
    endcase
  end

  // extra top bit catches the carry out of the increment
  assign rnd = {1'b0, in.mag} + {32'd0, inc};

  // negative side reaches one further, to 2^31
  assign range_ovf = in.sign ? (rnd[32] || (rnd[31] && (|rnd[30:0])))
                             : (rnd[32] || rnd[31]);

  assign invalid = in.nan || in.ovf || range_ovf;

  //////////////////////////////////////////////////
  // sign and saturation
  //////////////////////////////////////////////////

  always_comb begin
    if (invalid) begin
      res = in.sign ? fpu_f2i_pkg::INT_NEG_SAT : fpu_f2i_pkg::INT_POS_SAT;
    end else if (in.sign) begin
      res = -rnd[31:0];
    end else begin
      res = rnd[31:0];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      res_valid_o <= 1'b0;
    end else if (flush_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= in.vld;
    end
  end

  always_ff @(posedge clk) begin
    if (in.vld) begin
      res_int_o     <= res;
      res_invalid_o <= invalid;
      // invalid wins over inexact
      res_inexact_o <= inexact && !invalid;
    end
  end

  // NaN reaches this stage with its sign already cleared
  a_nan_pos: assert property (@(posedge clk) disable iff (rst)
    (in.vld && in.nan) |-> !in.sign);

endmodule

`default_nettype wire

// ==== design/fpu_f2i_top.sv ====
// float to signed int converter top level
// credit gate in front of a four stage conversion pipeline

`default_nettype none

module fpu_f2i_top #(
  parameter int CREDITS = 4
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  flush_i,
  // operand side
  input  wire                  in_valid_i,
  input  fpu_f2i_pkg::fp32_t   in_op_i,
  input  fpu_f2i_pkg::rm_t     in_rm_i,
  output wire                  in_ready_o,
  // result side
  input  wire                  credit_i,
  output wire                  res_valid_o,
  output fpu_f2i_pkg::int32_t  res_int_o,
  output wire                  res_invalid_o,
  output wire                  res_inexact_o
);

  wire accept;

  // stage links
  unpack_if i_unpack_if ();
  prep_if   i_prep_if ();
  shift_if  i_shift_if ();

  // credit gate, the result valid closes out an in-flight item
  fpu_f2i_credit #(
    .CREDITS (CREDITS)
  ) i_fpu_f2i_credit (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .credit_i    (credit_i),
    .res_valid_i (res_valid_o),
    .accept_o    (accept),
    .in_ready_o  (in_ready_o)
  );

  //////////////////////////////////////////////////
  // conversion pipeline
  //////////////////////////////////////////////////

  fpu_f2i_unpack i_fpu_f2i_unpack (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .vld_i   (accept),
    .op_i    (in_op_i),
    .rm_i    (in_rm_i),
    .out     (i_unpack_if.src)
  );

  fpu_f2i_prep i_fpu_f2i_prep (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .in      (i_unpack_if.dst),
    .out     (i_prep_if.src)
  );

  fpu_f2i_shift i_fpu_f2i_shift (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .in      (i_prep_if.dst),
    .out     (i_shift_if.src)
  );

  fpu_f2i_round i_fpu_f2i_round (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .in            (i_shift_if.dst),
    .res_valid_o   (res_valid_o),
    .res_int_o     (res_int_o),
    .res_invalid_o (res_invalid_o),
    .res_inexact_o (res_inexact_o)
  );

endmodule

`default_nettype wire

// ==== bench/tb_f2i_model.svh ====
// float to int reference model for the testbench
// exact conversion of accepted operands, queue of expected results

`ifndef TB_F2I_MODEL_SVH
`define TB_F2I_MODEL_SVH

// expected results in acceptance order, with the cycle of acceptance
fpu_f2i_pkg::int32_t exp_int_q[$];
logic                exp_inv_q[$];
logic                exp_inx_q[$];
int                  exp_cyc_q[$];

// value is mant * 2^pow, split into an integer part and a remainder
task automatic push_expected(
  input fpu_f2i_pkg::fp32_t op,
  input fpu_f2i_pkg::rm_t   rm,
  input int                 cyc_acc
);
  logic                sign;
  logic [7:0]          expf;
  logic [63:0]         mant;
  logic [63:0]         ipart;
  logic [63:0]         rem;
  logic [63:0]         half;
  int                  pow;
  logic                big;
  logic                up;
  logic                inv;
  fpu_f2i_pkg::int32_t res;
  sign  = op[31];
  expf  = op[30:23];
  // denormals have no hidden bit and the scale of exponent 1
  mant  = {40'd0, (expf != 8'h00), op[22:0]};
  pow   = (expf == 8'h00) ? -149 : int'(expf) - 150;
  big   = (pow > 31);
  ipart = 64'd0;
  rem   = 64'd0;
  // half of one unit, only matters when something was cut off
  half  = 64'd1;
  if (pow >= 0 && !big) begin
    ipart = mant << pow;
  end else if (pow < -40) begin
    // far below one half
    rem  = mant;
    half = 64'd1 << 62;
  end else if (pow < 0) begin
    ipart = mant >> (-pow);
    rem   = mant - (ipart << (-pow));
    half  = 64'd1 << (-pow - 1);
  end
  case (rm)
    fpu_f2i_pkg::RM_RTZ: up = 1'b0;
    fpu_f2i_pkg::RM_RDN: up = sign && (rem != 64'd0);
    fpu_f2i_pkg::RM_RUP: up = !sign && (rem != 64'd0);
    fpu_f2i_pkg::RM_RMM: up = (rem >= half);
    // nearest, ties go to the even integer
    default:             up = (rem > half) || ((rem == half) && ipart[0]);
  endcase
  ipart = ipart + {63'd0, up};
  // negative side reaches down to -2^31
  inv = big || (expf == 8'hff) ||
        (sign ? (ipart > 64'h8000_0000) : (ipart > 64'h7fff_ffff));
  if (expf == 8'hff && op[22:0] != 23'd0) begin
    res = fpu_f2i_pkg::INT_POS_SAT;
  end else if (inv) begin
    res = sign ? fpu_f2i_pkg::INT_NEG_SAT : fpu_f2i_pkg::INT_POS_SAT;
  end else begin
    res = sign ? -ipart[31:0] : ipart[31:0];
  end
  exp_int_q.push_back(res);
  exp_inv_q.push_back(inv);
  exp_inx_q.push_back(!inv && (rem != 64'd0));
  exp_cyc_q.push_back(cyc_acc);
endtask

`endif

// ==== bench/tb_fpu_f2i_top.sv ====
// testbench for the float to int pipeline
// random operands against a model, consumer buffer that returns credits

`default_nettype none

module tb_fpu_f2i_top;

  localparam int CREDITS   = 4;
  localparam int ORD_N     = 120;
  localparam int SAT_N     = 60;
  localparam int LAT_N     = 20;
  localparam int MIX_N     = 150;
  // six directed cases, credit test CREDITS+1, two flush cases 3*CREDITS+2
  localparam int TOTAL_OPS = ORD_N + SAT_N + 6 + LAT_N + MIX_N + 4 * CREDITS + 3;
  localparam int CYC_LIMIT = 4 * TOTAL_OPS + 200;

  logic                clk = 1'b0;
  logic                rst;
  logic                flush_i;
  logic                in_valid_i;
  fpu_f2i_pkg::fp32_t  in_op_i;
  fpu_f2i_pkg::rm_t    in_rm_i;
  logic                credit_i;
  wire                 in_ready_o;
  wire                 res_valid_o;
  fpu_f2i_pkg::int32_t res_int_o;
  wire                 res_invalid_o;
  wire                 res_inexact_o;

  integer seed = 67;
  int     cyc = 0;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     test_start = 0;
  int     killed = 0;
  int     acc_cyc;
  // consumer side state
  int     buf_cnt = 0;
  int     drain_pct = 50;
  logic   hold = 1'b0;
  logic   drain_req = 1'b0;

  `include "tb_f2i_model.svh"

  fpu_f2i_top #(
    .CREDITS (CREDITS)
  ) i_fpu_f2i_top (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .in_valid_i    (in_valid_i),
    .in_op_i       (in_op_i),
    .in_rm_i       (in_rm_i),
    .in_ready_o    (in_ready_o),
    .credit_i      (credit_i),
    .res_valid_o   (res_valid_o),
    .res_int_o     (res_int_o),
    .res_invalid_o (res_invalid_o),
    .res_inexact_o (res_inexact_o)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // checks and reporting
  //////////////////////////////////////////////////

  task automatic check_int(input string name, input fpu_f2i_pkg::int32_t got,
                           input fpu_f2i_pkg::int32_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %-14s %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // 0 ordinary, 1 near 2^31, 2 denormal, 3 infinity, 4 qnan, 5 snan, else below one
  function automatic fpu_f2i_pkg::fp32_t gen_operand(input int kind);
    fpu_f2i_pkg::fp32_t op;
    op = $random(seed);
    case (kind)
      0: op[30:23] = 8'd120 + 8'({$random(seed)} % 38);
      1: op[30:23] = 8'd156 + 8'({$random(seed)} % 5);
      2: op[30:23] = 8'd0;
      3: op[30:0]  = 31'h7f80_0000;
      4: op[30:22] = 9'h1ff;
      5: begin
        op[30:22] = 9'h1fe;
        op[0]     = 1'b1;
      end
      default: op[30:23] = 8'd110 + 8'({$random(seed)} % 18);
    endcase
    return op;
  endfunction

  // entered and left a little after the rising edge
  task automatic issue(input fpu_f2i_pkg::fp32_t op, input fpu_f2i_pkg::rm_t rm);
    in_valid_i = 1'b1;
    in_op_i    = op;
    in_rm_i    = rm;
    // operand waits here until a credit lets it in
    @(negedge clk);
    while (!in_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    in_valid_i = 1'b0;
  endtask

  task automatic issue_kind(input int kind);
    issue(gen_operand(kind), 3'($random(seed)));
  endtask

  // every result delivered and every credit back in the counter
  task automatic wait_drained();
    do begin
      @(negedge clk);
    end while (exp_int_q.size() != 0 || buf_cnt != 0);
    repeat (2) @(posedge clk);
    #2;
  endtask

  task automatic flush_case(input int n_ops);
    int room;
    int kill_start;
    hold       = 1'b1;
    kill_start = killed;
    repeat (n_ops) issue_kind(0);
    flush_i = 1'b1;
    @(posedge clk);
    #2;
    flush_i = 1'b0;
    // three stages hold items, anything older is already showing
    if (killed - kill_start != ((n_ops < 3) ? n_ops : 3)) begin
      report_failure($sformatf("flush killed %0d items", killed - kill_start));
    end
    // killed items gave back their credits, stored results still hold theirs
    room = CREDITS - buf_cnt;
    repeat (room) issue_kind(0);
    @(negedge clk);
    check_flag("in_ready_o", in_ready_o, 1'b0);
    @(posedge clk);
    #2;
    hold = 1'b0;
    wait_drained();
  endtask

  //////////////////////////////////////////////////
  // monitor and consumer
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst) begin
      // delivered results first, so a same-cycle accept never gets popped
      if (res_valid_o) begin
        if (exp_int_q.size() == 0) begin
          report_failure("result delivered with no operand in flight");
        end else begin
          acc_cyc = exp_cyc_q.pop_front();
          if (cyc - acc_cyc != 4) begin
            report_failure($sformatf("result latency %0d cycles instead of 4", cyc - acc_cyc));
          end
          check_int("res_int_o", res_int_o, exp_int_q.pop_front());
          check_flag("res_invalid_o", res_invalid_o, exp_inv_q.pop_front());
          check_flag("res_inexact_o", res_inexact_o, exp_inx_q.pop_front());
        end
        buf_cnt++;
        if (buf_cnt > CREDITS) begin
          report_failure("consumer buffer holds more results than it has slots");
        end
      end
      // items still in the pipe die with the flush
      if (flush_i) begin
        killed += exp_int_q.size();
        exp_int_q.delete();
        exp_inv_q.delete();
        exp_inx_q.delete();
        exp_cyc_q.delete();
      end
      if (in_valid_i && in_ready_o) begin
        push_expected(in_op_i, in_rm_i, cyc);
      end
      // consumer frees a slot at random, credit goes out next cycle
      drain_req = !hold && (buf_cnt > 0) && (({$random(seed)} % 100) < drain_pct);
      if (drain_req) begin
        buf_cnt--;
      end
    end
  end

  always @(posedge clk) begin
    #2;
    credit_i = drain_req;
  end

  // cycle count for latency and the run limit
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > CYC_LIMIT) begin
      $display("run stopped at the cycle limit of %0d", CYC_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    in_op_i    = '0;
    in_rm_i    = '0;
    credit_i   = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    // one cycle after release the gate is open and nothing is showing
    @(posedge clk);
    @(negedge clk);
    check_flag("res_valid_o", res_valid_o, 1'b0);
    check_flag("in_ready_o", in_ready_o, 1'b1);
    @(posedge clk);
    #2;
    finish_test("reset");

    for (int i = 0; i < ORD_N; i++) begin
      issue(gen_operand((i % 2 == 0) ? 0 : 6), 3'(i % 5));
    end
    wait_drained();
    finish_test("ordinary");

    // +2^31, -2^31, largest in range, just past -2^31, infinities
    issue(32'h4f00_0000, fpu_f2i_pkg::RM_RNE);
    issue(32'hcf00_0000, fpu_f2i_pkg::RM_RTZ);
    issue(32'h4eff_ffff, fpu_f2i_pkg::RM_RUP);
    issue(32'hcf00_0001, fpu_f2i_pkg::RM_RDN);
    issue(32'h7f80_0000, fpu_f2i_pkg::RM_RMM);
    issue(32'hff80_0000, fpu_f2i_pkg::RM_RNE);
    for (int i = 0; i < SAT_N; i++) begin
      issue_kind(1 + i % 5);
    end
    wait_drained();
    finish_test("saturation");

    // consumer takes every result at once
    drain_pct = 100;
    repeat (LAT_N) issue_kind(0);
    wait_drained();
    drain_pct = 50;
    finish_test("latency");

    hold = 1'b1;
    repeat (CREDITS) issue_kind(0);
    @(negedge clk);
    check_flag("in_ready_o", in_ready_o, 1'b0);
    @(posedge clk);
    #2;
    fork
      issue_kind(0);
      begin
        repeat (8) @(posedge clk);
        #2;
        if (buf_cnt != CREDITS) begin
          report_failure($sformatf("consumer holds %0d results with no credit back", buf_cnt));
        end
        hold = 1'b0;
      end
    join
    wait_drained();
    finish_test("credit limit");

    flush_case(3);
    flush_case(CREDITS);
    finish_test("flush");

    repeat (MIX_N) issue_kind({$random(seed)} % 7);
    wait_drained();
    finish_test("random mix");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/fpu_f2i_pkg.sv
common/fpu_f2i_if.sv
design/fpu_f2i_credit.sv
f2i/fpu_f2i_unpack.sv
f2i/fpu_f2i_prep.sv
f2i/fpu_f2i_shift.sv
f2i/fpu_f2i_round.sv
design/fpu_f2i_top.sv
+incdir+bench
bench/tb_fpu_f2i_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the float to int testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fpu_f2i_top \
  -f filelist.f -o sim_f2i

out=$(./obj_dir/sim_f2i)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
